//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Widths shared by the cache datapath and the memory port
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;     // One strobe per byte lane
    localparam int FILL_WAY_W = 8;              // Fill way index, room for 256 ways

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_e;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,     // Waiting for AR, or AW and W together
        LOOKUP  = 3'd1,     // Tag compare, then hit or miss decision
        MEM_REQ = 3'd2,     // Word fetch or write-through in flight
        FILL    = 3'd3,     // Fetched word goes into the victim way
        RESP_R  = 3'd4,
        RESP_B  = 3'd5
    } ctrl_state_e;

    // One access as seen by the way array and the LRU tracker
    typedef struct packed {
        logic       valid;      // Compare strobe, one cycle
        access_op_e op;
        addr_t      addr;       // Also selects the set while valid is low
        data_t      wdata;
        strb_t      wstrb;
    } lookup_req_t;

    typedef struct packed {
        logic                  valid;
        logic [FILL_WAY_W-1:0] way;
        addr_t                 addr;    // Set index and tag come from here
        data_t                 data;
    } fill_req_t;

    // Word-wide memory port, request held until ack
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } mem_req_t;

    typedef struct packed {
        logic  ack;         // Single cycle
        data_t rdata;       // Valid with ack on reads
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    // Response codes on BRESP and RRESP
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Master to slave, all five channels
    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- cache_ways.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ways #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire cache_pkg::lookup_req_t lookup_i,       // Access from the controller
    input  wire cache_pkg::fill_req_t   fill_i,         // Line install after a read miss
    output logic                        hit_o,
    output logic [NUM_WAYS-1:0]         hit_way_o,      // One-hot or zero
    output cache_pkg::data_t            rdata_o,
    output logic [NUM_WAYS-1:0]         set_valid_o     // Valid bits of the looked-up set
);
    import cache_pkg::*;

    localparam int OFF_W = $clog2(STRB_W);              // Byte select bits
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFF_W;      // Everything above the index
    localparam int WAY_W = $clog2(NUM_WAYS);

    // Storage, one entry per set and way
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
    data_t               data_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];

    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic [IDX_W-1:0]    fill_idx;
    logic [TAG_W-1:0]    fill_tag;
    logic [WAY_W-1:0]    fill_way;
    logic [NUM_WAYS-1:0] hit_vec;
    data_t               hit_data;
    logic                wr_hit;

    // Replace the strobed byte lanes of a stored word
    function automatic data_t merge_bytes(data_t old_d, data_t new_d, strb_t strb);
        data_t d;
        d = old_d;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                d[8*b +: 8] = new_d[8*b +: 8];
            end
        end
        return d;
    endfunction

    assign idx      = lookup_i.addr[OFF_W +: IDX_W];
    assign tag      = lookup_i.addr[ADDR_W-1 -: TAG_W];
    assign fill_idx = fill_i.addr[OFF_W +: IDX_W];
    assign fill_tag = fill_i.addr[ADDR_W-1 -: TAG_W];
    assign fill_way = fill_i.way[WAY_W-1:0];            // Upper bits unused for small caches

    // Parallel tag compare across all ways of the set
    always_comb begin
        hit_vec  = '0;
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[idx][w] && (tag_mem[idx][w] == tag);
            if (hit_vec[w]) begin
                hit_data = hit_data | data_mem[idx][w];   // At most one way contributes
            end
        end
    end

    assign wr_hit = lookup_i.valid && (lookup_i.op == OP_WRITE) && (|hit_vec);

    // Lookup result, held until the next compare
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hit_o       <= 1'b0;
            hit_way_o   <= '0;
            set_valid_o <= '0;
        end else if (lookup_i.valid) begin
            hit_o       <= |hit_vec;
            hit_way_o   <= hit_vec;
            set_valid_o <= valid_q[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_i.valid) begin
            rdata_o <= hit_data;        // Old word on a write hit, unused there
        end
    end

    // Valid bits only ever get set by a fill
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_i.valid) begin
            valid_q[fill_idx][fill_way] <= 1'b1;
        end
    end

    // Fill and lookup never share a cycle
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            tag_mem[fill_idx][fill_way]  <= fill_tag;
            data_mem[fill_idx][fill_way] <= fill_i.data;
        end else if (wr_hit) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (hit_vec[w]) begin
                    data_mem[idx][w] <= merge_bytes(data_mem[idx][w], lookup_i.wdata,
                                                    lookup_i.wstrb);
                end
            end
        end
    end

    // A tag sits in one way only, so fills must follow real misses
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(hit_way_o));

endmodule

`default_nettype wire

//--- lru_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module lru_tracker #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 4
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire cache_pkg::lookup_req_t  lookup_i,      // Address picks the set
    input  wire logic [NUM_WAYS-1:0]     set_valid_i,
    input  wire logic                    touch_i,       // Way was just used
    input  wire logic [NUM_WAYS-1:0]     touch_way_i,
    output logic [$clog2(NUM_WAYS)-1:0]  victim_way_o
);
    import cache_pkg::*;

    localparam int OFF_W = $clog2(STRB_W);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);

    // Rank per way, 0 is most recent, NUM_WAYS-1 is oldest
    logic [WAY_W-1:0] age_q [NUM_SETS][NUM_WAYS];

    logic [IDX_W-1:0] idx;
    logic [WAY_W-1:0] touch_age;    // Age of the touched way before the update
    logic [WAY_W-1:0] max_age;
    logic             found_free;

    assign idx = lookup_i.addr[OFF_W +: IDX_W];

    // Victim: lowest invalid way first, else the oldest
    always_comb begin
        victim_way_o = '0;
        found_free   = 1'b0;
        max_age      = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!set_valid_i[w] && !found_free) begin
                victim_way_o = WAY_W'(w);
                found_free   = 1'b1;
            end
        end
        if (!found_free) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (age_q[idx][w] >= max_age) begin
                    max_age      = age_q[idx][w];
                    victim_way_o = WAY_W'(w);
                end
            end
        end
    end

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (touch_way_i[w]) begin
                touch_age = touch_age | age_q[idx][w];
            end
        end
    end

    // Ranks stay a permutation; only younger ways move up by one
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= WAY_W'(w);       // Distinct from the start
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (touch_way_i[w]) begin
                    age_q[idx][w] <= '0;
                end else if (age_q[idx][w] < touch_age) begin
                    age_q[idx][w] <= age_q[idx][w] + 1'b1;
                end
            end
        end
    end

    a_touch_onehot: assert property (@(posedge clk) disable iff (reset_i)
        touch_i |-> $onehot(touch_way_i));

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 4
) (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire axi_lite_pkg::axil_req_t     axil_req_i,
    output axi_lite_pkg::axil_rsp_t          axil_rsp_o,
    output cache_pkg::lookup_req_t           lookup_o,      // To ways and LRU
    input  wire logic                        hit_i,
    input  wire logic [NUM_WAYS-1:0]         hit_way_i,
    input  wire cache_pkg::data_t            rdata_i,
    input  wire logic [$clog2(NUM_WAYS)-1:0] victim_way_i,
    output cache_pkg::fill_req_t             fill_o,
    output logic                             touch_o,
    output logic [NUM_WAYS-1:0]              touch_way_o,
    output cache_pkg::mem_req_t              mem_req_o,
    input  wire cache_pkg::mem_rsp_t         mem_rsp_i
);
    import cache_pkg::*;
    import axi_lite_pkg::*;

    // Index math in the arrays relies on powers of two
    if ((NUM_SETS & (NUM_SETS - 1)) != 0 || NUM_SETS < 2) begin : g_bad_sets
        $error("NUM_SETS must be a power of two, at least 2");
    end
    if ((NUM_WAYS & (NUM_WAYS - 1)) != 0 || NUM_WAYS < 2 || NUM_WAYS > 256) begin : g_bad_ways
        $error("NUM_WAYS must be a power of two from 2 to 256");
    end

    ctrl_state_e state_q, state_d;
    logic        cmp_done_q;        // Second LOOKUP cycle, hit_i is valid
    lookup_req_t req_q;             // Accepted AXI transaction
    data_t       rdata_q;           // Read data for the R channel
    logic        ar_take;
    logic        aw_take;
    logic        decide;

    // Reads win when both channels are pending
    assign ar_take = (state_q == IDLE) && axil_req_i.arvalid;
    assign aw_take = (state_q == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid
                     && !axil_req_i.arvalid;
    assign decide  = (state_q == LOOKUP) && cmp_done_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (ar_take || aw_take) state_d = LOOKUP;
            LOOKUP: begin
                if (cmp_done_q) begin
                    if (req_q.op == OP_READ && hit_i) begin
                        state_d = RESP_R;           // Served from the array
                    end else begin
                        state_d = MEM_REQ;          // Read miss or write-through
                    end
                end
            end
            MEM_REQ: begin
                if (mem_rsp_i.ack) begin
                    state_d = (req_q.op == OP_READ) ? FILL : RESP_B;
                end
            end
            FILL:    state_d = RESP_R;
            RESP_R:  if (axil_req_i.rready) state_d = IDLE;
            RESP_B:  if (axil_req_i.bready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            cmp_done_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            cmp_done_q <= (state_q == LOOKUP) && !cmp_done_q;
        end
    end

    // Transaction and read data capture
    always_ff @(posedge clk) begin
        if (ar_take) begin
            req_q.op    <= OP_READ;
            req_q.addr  <= axil_req_i.araddr;
            req_q.wdata <= '0;
            req_q.wstrb <= '0;
        end else if (aw_take) begin
            req_q.op    <= OP_WRITE;
            req_q.addr  <= axil_req_i.awaddr;
            req_q.wdata <= axil_req_i.wdata;
            req_q.wstrb <= axil_req_i.wstrb;
        end
        req_q.valid <= ar_take || aw_take;      // High in the first LOOKUP cycle only
        if (decide && hit_i) begin
            rdata_q <= rdata_i;
        end else if (state_q == MEM_REQ && mem_rsp_i.ack) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    always_comb begin
        lookup_o = req_q;                       // Compare strobe rides along in valid

        // Hit way on a hit, victim once it is filled
        touch_o     = (decide && hit_i) || (state_q == FILL);
        touch_way_o = (state_q == FILL) ? (NUM_WAYS'(1) << victim_way_i) : hit_way_i;

        fill_o.valid = (state_q == FILL);
        fill_o.way   = FILL_WAY_W'(victim_way_i);
        fill_o.addr  = req_q.addr;
        fill_o.data  = rdata_q;

        mem_req_o.valid = (state_q == MEM_REQ);
        mem_req_o.we    = (req_q.op == OP_WRITE);
        mem_req_o.addr  = req_q.addr;
        mem_req_o.wdata = req_q.wdata;
        mem_req_o.wstrb = req_q.wstrb;

        axil_rsp_o.arready = ar_take;
        axil_rsp_o.awready = aw_take;           // AW and W always accepted together
        axil_rsp_o.wready  = aw_take;
        axil_rsp_o.bvalid  = (state_q == RESP_B);
        axil_rsp_o.bresp   = RESP_OKAY;
        axil_rsp_o.rvalid  = (state_q == RESP_R);
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = RESP_OKAY;
    end

    // Memory side sees a steady request until it acknowledges
    a_mem_stable: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o.valid && !mem_rsp_i.ack |=> mem_req_o.valid && $stable(mem_req_o));

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 4
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire axi_lite_pkg::axil_req_t axil_req_i,     // CPU side
    output axi_lite_pkg::axil_rsp_t      axil_rsp_o,
    output cache_pkg::mem_req_t          mem_req_o,      // Word-wide memory side
    input  wire cache_pkg::mem_rsp_t     mem_rsp_i
);
    import cache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    lookup_req_t         lookup;
    fill_req_t           fill;
    logic                hit;
    logic [NUM_WAYS-1:0] hit_way;
    data_t               hit_rdata;
    logic [NUM_WAYS-1:0] set_valid;
    logic [WAY_W-1:0]    victim_way;
    logic                touch;
    logic [NUM_WAYS-1:0] touch_way;

    // FSM, owns the AXI and memory handshakes
    cache_ctrl #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) cache_ctrl_i (
        .clk, .reset_i,
        .axil_req_i, .axil_rsp_o,
        .lookup_o     (lookup),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .rdata_i      (hit_rdata),
        .victim_way_i (victim_way),
        .fill_o       (fill),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .mem_req_o, .mem_rsp_i
    );

    cache_ways #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) cache_ways_i (
        .clk, .reset_i,
        .lookup_i    (lookup),
        .fill_i      (fill),
        .hit_o       (hit),
        .hit_way_o   (hit_way),
        .rdata_o     (hit_rdata),
        .set_valid_o (set_valid)
    );

    // Same set as the way array, picked by the same lookup address
    lru_tracker #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) lru_tracker_i (
        .clk, .reset_i,
        .lookup_i     (lookup),
        .set_valid_i  (set_valid),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the DUT's sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;
    import cache_pkg::*;
    import axi_lite_pkg::*;

    localparam int NUM_SETS       = 16;
    localparam int NUM_WAYS       = 4;
    localparam int OFF_W          = 2;                 // Byte select bits
    localparam int IDX_W          = $clog2(NUM_SETS);
    localparam int MEM_WORDS      = 4096;              // 16 KB model, all test addresses fit
    localparam int MEM_AW         = $clog2(MEM_WORDS);
    localparam int NUM_RANDOM_OPS = 2000;
    localparam int TIMEOUT_CYCLES = NUM_RANDOM_OPS * 20;   // Twice the usual access length
    localparam int SEED           = 77;
    localparam int LRU_SET        = 9;
    localparam int LRU_TAG_BASE   = 8;
    localparam logic [1:0] AXI_OKAY = 2'b00;           // Only response the cache gives

    logic      clk;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp = '0;

    // Memory model and its delay state
    data_t mem_words [MEM_WORDS];
    int    mem_delay;
    logic  mem_busy = 1'b0;

    // Reference cache and its own memory image
    data_t ref_mem   [MEM_WORDS];
    logic  ref_valid [NUM_SETS][NUM_WAYS];
    addr_t ref_tag   [NUM_SETS][NUM_WAYS];
    int    ref_age   [NUM_SETS][NUM_WAYS];     // 0 is most recent
    int    exp_reads = 0;

    // Handshake bookkeeping, updated on rising edges
    int    cycle       = 0;
    int    ar_hs       = 0;
    int    aw_hs       = 0;
    int    r_hs        = 0;
    int    b_hs        = 0;
    int    ar_cyc      = 0;
    int    rv_rise_cyc = 0;
    logic  rvalid_prev = 1'b0;
    data_t r_data;
    logic [1:0] r_resp = '0;
    logic [1:0] b_resp = '0;
    int    mem_reads   = 0;

    string name_q [$];
    data_t exp_q  [$];
    data_t act_q  [$];
    int    data_errors  = 0;
    int    count_errors = 0;
    int    resp_errors  = 0;

    // Tag order for the eviction test, LRU set
    int lru_order [12] = '{0, 1, 2, 3, 0, 2, 4, 1, 3, 0, 4, 2};

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) tb_clock_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    cache_top #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) cache_top_i (
        .clk,
        .reset_i    (reset),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    // Power-up memory contents, a hash of the full byte address
    function automatic data_t fill_word(addr_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'hC0DE_0000;
    endfunction

    function automatic int word_of(addr_t addr);
        return int'(addr[OFF_W +: MEM_AW]);
    endfunction

    function automatic data_t apply_strobe(data_t old_d, data_t new_d, strb_t strb);
        data_t d;
        for (int b = 0; b < STRB_W; b++) begin
            d[8*b +: 8] = strb[b] ? new_d[8*b +: 8] : old_d[8*b +: 8];
        end
        return d;
    endfunction

    // Rank update, younger ways age by one
    function automatic void ref_touch(int s_idx, int way);
        int old_age;
        old_age = ref_age[s_idx][way];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) begin
                ref_age[s_idx][w] = 0;
            end else if (ref_age[s_idx][w] < old_age) begin
                ref_age[s_idx][w] = ref_age[s_idx][w] + 1;
            end
        end
    endfunction

    // Expected read data; returns 1 when the access must read memory
    function automatic bit ref_access(input bit is_write, input addr_t addr, input data_t wdata,
                                      input strb_t wstrb, output data_t rdata);
        int    s_idx;
        addr_t tag;
        int    hit_way;
        int    victim;
        s_idx   = int'(addr[OFF_W +: IDX_W]);
        tag     = addr >> (OFF_W + IDX_W);
        hit_way = -1;
        victim  = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin       // Downward, lowest wins
            if (ref_valid[s_idx][w] && ref_tag[s_idx][w] == tag) hit_way = w;
            if (!ref_valid[s_idx][w]) victim = w;
        end
        if (is_write) begin
            ref_mem[word_of(addr)] = apply_strobe(ref_mem[word_of(addr)], wdata, wstrb);
            if (hit_way >= 0) ref_touch(s_idx, hit_way);     // No allocate on a miss
            rdata = '0;
            return 1'b0;
        end
        rdata = ref_mem[word_of(addr)];
        if (hit_way >= 0) begin
            ref_touch(s_idx, hit_way);
            return 1'b0;
        end
        if (victim < 0) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (ref_age[s_idx][w] == NUM_WAYS - 1) victim = w;   // Ranks are a permutation
            end
        end
        ref_valid[s_idx][victim] = 1'b1;
        ref_tag[s_idx][victim]   = tag;
        ref_touch(s_idx, victim);
        return 1'b1;
    endfunction

    task automatic check_data(input string name, input cache_pkg::data_t exp_d,
                              input cache_pkg::data_t act_d);
        if (act_d !== exp_d) begin
            data_errors++;
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp_d, act_d);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            count_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_n, act_n);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp_r,
                              input logic [1:0] act_r);
        if (act_r !== exp_r) begin
            resp_errors++;
            $display("CHECK FAILED %s: expected %02b, actual %02b", name, exp_r, act_r);
        end
    endtask

    task automatic queue_compare(input string name, input data_t exp_d, input data_t act_d);
        name_q.push_back(name);
        exp_q.push_back(exp_d);
        act_q.push_back(act_d);
    endtask

    // AXI master side, called and returning on a falling edge
    task automatic axi_read(input addr_t addr, input bit stall, output data_t data);
        int ar_seen;
        int r_seen;
        ar_seen          = ar_hs;
        r_seen           = r_hs;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        do @(negedge clk); while (ar_hs == ar_seen);
        axil_req.arvalid = 1'b0;
        do begin
            axil_req.rready = stall ? ($urandom % 4 != 0) : 1'b1;   // Random back-pressure
            @(negedge clk);
        end while (r_hs == r_seen);
        axil_req.rready = 1'b0;
        data = r_data;
    endtask

    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             input bit stall);
        int aw_seen;
        int b_seen;
        aw_seen          = aw_hs;
        b_seen           = b_hs;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;    // W together with AW
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        do @(negedge clk); while (aw_hs == aw_seen);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        do begin
            axil_req.bready = stall ? ($urandom % 4 != 0) : 1'b1;
            @(negedge clk);
        end while (b_hs == b_seen);
        axil_req.bready = 1'b0;
    endtask

    task automatic do_read(input string name, input addr_t addr, input bit stall);
        data_t exp_d;
        data_t act_d;
        bit    exp_miss;
        int    reads0;
        reads0   = mem_reads;
        exp_miss = ref_access(1'b0, addr, '0, '0, exp_d);
        axi_read(addr, stall, act_d);
        queue_compare(name, exp_d, act_d);
        check_resp({name, " rresp"}, AXI_OKAY, r_resp);
        exp_reads += int'(exp_miss);
        check_count({name, " mem reads"}, int'(exp_miss), mem_reads - reads0);
    endtask

    // Write-through must land in memory whether or not it hits
    task automatic do_write(input string name, input addr_t addr, input data_t data,
                            input strb_t strb, input bit stall);
        data_t unused_d;
        void'(ref_access(1'b1, addr, data, strb, unused_d));
        axi_write(addr, data, strb, stall);
        check_resp({name, " bresp"}, AXI_OKAY, b_resp);
        queue_compare({name, " memory word"}, ref_mem[word_of(addr)],
                      mem_words[word_of(addr)]);
    endtask

    // Memory model, ack after 1 to 5 cycles, driven on falling edges
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = fill_word(addr_t'(i << OFF_W));
        end
        forever begin
            @(negedge clk);
            if (mem_rsp.ack) begin
                mem_rsp.ack = 1'b0;     // Single-cycle ack
                mem_busy    = 1'b0;
            end else if (mem_req.valid) begin
                if (!mem_busy) begin
                    mem_busy  = 1'b1;
                    mem_delay = 1 + int'($urandom % 5);
                end
                mem_delay = mem_delay - 1;
                if (mem_delay == 0) begin
                    mem_rsp.ack = 1'b1;
                    if (mem_req.we) begin
                        mem_words[word_of(mem_req.addr)] =
                            apply_strobe(mem_words[word_of(mem_req.addr)], mem_req.wdata,
                                         mem_req.wstrb);
                    end else begin
                        mem_rsp.rdata = mem_words[word_of(mem_req.addr)];
                    end
                end
            end
        end
    end

    // Pre-edge values of both sides
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (axil_req.arvalid && axil_rsp.arready) begin
            ar_hs  = ar_hs + 1;
            ar_cyc = cycle;
        end
        if (axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready) begin
            aw_hs = aw_hs + 1;
        end
        if (axil_rsp.rvalid && axil_req.rready) begin
            r_hs   = r_hs + 1;
            r_data = axil_rsp.rdata;
            r_resp = axil_rsp.rresp;
        end
        if (axil_rsp.bvalid && axil_req.bready) begin
            b_hs   = b_hs + 1;
            b_resp = axil_rsp.bresp;
        end
        if (axil_rsp.rvalid && !rvalid_prev) rv_rise_cyc = cycle;
        rvalid_prev = axil_rsp.rvalid;
        if (mem_req.valid && !mem_req.we && mem_rsp.ack) mem_reads = mem_reads + 1;
    end

    always @(posedge clk) begin
        while (act_q.size() > 0 && exp_q.size() > 0) begin
            check_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle);
        $display("Test failed");
        $finish;
    end

    initial begin
        addr_t a;
        strb_t s;
        int    reads0;
        int    exp_reads0;
        void'($urandom(SEED));
        axil_req = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_word(addr_t'(i << OFF_W));
        end
        for (int si = 0; si < NUM_SETS; si++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[si][w] = 1'b0;
                ref_tag[si][w]   = '0;
                ref_age[si][w]   = w;       // Same start ranks as after reset
            end
        end
        @(negedge clk);
        while (reset) @(negedge clk);

        // Miss then hit on one address
        a = 32'h0000_0120;
        do_read("t1 first read", a, 1'b0);
        do_read("t1 repeat read", a, 1'b0);
        check_count("t1 hit latency", 2, rv_rise_cyc - ar_cyc - 1);   // Rise edge is before sample

        // Partial write into the cached line
        s = strb_t'(1 + $urandom % 15);
        do_write("t2 write hit", a, data_t'($urandom), s, 1'b0);
        do_read("t2 merged read", a, 1'b0);

        // No allocate on a write miss
        a = 32'h0000_0A44;
        do_write("t3 write miss", a, data_t'($urandom), 4'hF, 1'b0);
        do_read("t3 read after write miss", a, 1'b0);

        for (int i = 0; i < 12; i++) begin
            a = addr_t'(((LRU_TAG_BASE + lru_order[i]) << (OFF_W + IDX_W)) | (LRU_SET << OFF_W));
            do_read($sformatf("t4 read %0d tag %0d", i, lru_order[i]), a, 1'b0);
        end

        // Random mix over 256 words, with stalls
        reads0     = mem_reads;
        exp_reads0 = exp_reads;
        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            a = addr_t'(($urandom % 256) << OFF_W);
            if ($urandom % 5 < 3) begin
                do_read($sformatf("t5 op %0d read", i), a, 1'b1);
            end else begin
                s = strb_t'(1 + $urandom % 15);
                do_write($sformatf("t5 op %0d write", i), a, data_t'($urandom), s, 1'b1);
            end
        end
        check_count("t5 total mem reads", exp_reads - exp_reads0, mem_reads - reads0);

        // One rising edge drains the compare queues
        @(negedge clk);
        @(negedge clk);
        $display("Errors: %0d data, %0d count, %0d response", data_errors, count_errors,
                 resp_errors);
        if (data_errors == 0 && count_errors == 0 && resp_errors == 0 && act_q.size() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sv_cache.f
cache_pkg.sv
axi_lite_pkg.sv
cache_ways.sv
lru_tracker.sv
cache_ctrl.sv
cache_top.sv
tb_clock.sv
cache_tb.sv

//--- Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
RTL_TOP   ?= cache_top
FILELIST  ?= sv_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
